//--- src/vlsu_pkg.sv
// Shared widths, types and byte helpers of the vector load/store unit
package vlsu_pkg;

  localparam int unsigned ELEN       = 32;
  localparam int unsigned ELENB      = ELEN / 8;
  localparam int unsigned VREG_WORDS = 8;

  typedef logic [ELEN-1:0]  elen_t;
  typedef logic [ELENB-1:0] strb_t;
  typedef logic [15:0]      vlen_t;
  typedef logic [7:0]       vreg_addr_t;
  typedef logic [4:0]       vreg_num_t;
  typedef logic [2:0]       trans_id_t;

  typedef enum logic [1:0] {
    VLE,
    VSE,
    VLSE,
    VSSE
  } vlsu_op_e;

  // Encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vsew_e;

  typedef struct packed {
    vlsu_op_e  op;
    vsew_e     vsew;
    vlen_t     vl;      // Elements on input, bytes once registered
    elen_t     base;
    elen_t     stride;  // In bytes
    vreg_num_t vd;
    trans_id_t id;
  } vlsu_req_t;

  typedef struct packed {
    trans_id_t id;
    vreg_num_t vd;
  } vlsu_rsp_t;

  function automatic int unsigned id_width(int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic vlen_t elem_size(vsew_e vsew);
    return vlen_t'(1) << vsew;
  endfunction

  // Rotate a word left by whole bytes
  function automatic elen_t rotl_bytes(elen_t data, logic [1:0] n);
    logic [2*ELEN-1:0] dbl;
    dbl = {data, data} << (8 * n);
    return dbl[2*ELEN-1:ELEN];
  endfunction

  // One element at byte pos, or the low step bytes of a whole-word access
  function automatic strb_t access_strb(logic elem_wise, vsew_e vsew, logic [1:0] pos,
                                        vlen_t step);
    strb_t strb;
    if (elem_wise) begin
      unique case (vsew)
        EW_8:    strb = 4'b0001;
        EW_16:   strb = 4'b0011;
        default: strb = 4'b1111;
      endcase
      strb = strb << pos;
    end else begin
      for (int k = 0; k < ELENB; k++) begin
        strb[k] = vlen_t'(k) < step;
      end
    end
    return strb;
  endfunction

endpackage

//--- src/vlsu_cmd_if.sv
// Active instruction from the controller to both sequencers, with their done levels
interface vlsu_cmd_if import vlsu_pkg::*; ();

  logic      start;        // Pulse on request accept
  logic      active;       // Instruction held
  logic      is_load;
  logic      elem_wise;    // One element per access
  vsew_e     vsew;
  elen_t     base;
  elen_t     stride;
  vlen_t     total_bytes;
  vreg_num_t vd;

  logic      mem_done;
  logic      vrf_done;

  modport ctrl (
    output start, active, is_load, elem_wise, vsew, base, stride, total_bytes, vd,
    input  mem_done, vrf_done
  );

  modport mem (
    input  start, active, is_load, elem_wise, vsew, base, stride, total_bytes,
    output mem_done
  );

  modport vrf (
    input  start, active, is_load, elem_wise, vsew, total_bytes, vd,
    output vrf_done
  );

endinterface

//--- src/vlsu_buf_if.sv
// Link between one sequencer and the reorder buffer
interface vlsu_buf_if import vlsu_pkg::*; #(
  parameter  int unsigned NrOutstandingLoads = 4,
  localparam int unsigned IdWidth            = id_width(NrOutstandingLoads)
) ();

  // In-order allocation
  logic               alloc;
  logic [IdWidth-1:0] alloc_id;
  logic               full;

  // Write by id
  logic               push;
  logic [IdWidth-1:0] push_id;
  elen_t              push_data;

  // Oldest slot
  logic               head_valid;
  elen_t              head_data;
  logic               pop;

  modport seq (
    output alloc, push, push_id, push_data, pop,
    input  alloc_id, full, head_valid, head_data
  );

  modport rob (
    input  alloc, push, push_id, push_data, pop,
    output alloc_id, full, head_valid, head_data
  );

endinterface

//--- src/vlsu_ctrl.sv
// Instruction register, byte length conversion, access mode decode and response
module vlsu_ctrl import vlsu_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  vlsu_req_t req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output vlsu_rsp_t rsp_o,
  output logic      rsp_valid_o,
  vlsu_cmd_if.ctrl  cmd
);

  vlsu_req_t req_d;
  vlsu_req_t req_q;
  logic      active;
  logic      finish;
  logic      accept;
  logic      is_strided;

  // A held vl of zero bytes means no instruction
  assign active      = req_q.vl != '0;
  assign finish      = active & cmd.mem_done & cmd.vrf_done;
  assign req_ready_o = ~active | finish;
  assign accept      = req_valid_i & req_ready_o;

  always_comb begin
    req_d    = req_i;
    req_d.vl = req_i.vl << req_i.vsew;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q <= '0;
    end else if (accept) begin
      req_q <= req_d;
    end else if (finish) begin
      req_q <= '0;
    end
  end

  ////////////////////////////////////////
  // Decode

  assign is_strided = (req_q.op == VLSE) | (req_q.op == VSSE);

  assign cmd.start   = accept;
  assign cmd.active  = active;
  assign cmd.is_load = (req_q.op == VLE) | (req_q.op == VLSE);
  // Unaligned unit stride walks element by element
  assign cmd.elem_wise   = is_strided | (req_q.base[1:0] != 2'b00);
  assign cmd.vsew        = req_q.vsew;
  assign cmd.base        = req_q.base;
  assign cmd.stride      = is_strided ? req_q.stride : elen_t'(elem_size(req_q.vsew));
  assign cmd.total_bytes = req_q.vl;
  assign cmd.vd          = req_q.vd;

  // Frees the scoreboard entry
  assign rsp_valid_o = finish;
  assign rsp_o       = '{id: req_q.id, vd: req_q.vd};

endmodule

//--- src/vlsu_mem_seq.sv
// Memory side sequencer: addresses, strobes, store data and load result capture
module vlsu_mem_seq import vlsu_pkg::*; #(
  parameter  int unsigned NrOutstandingLoads = 4,
  localparam int unsigned IdWidth            = id_width(NrOutstandingLoads)
) (
  input  logic               clk_i,
  input  logic               reset_i,
  vlsu_cmd_if.mem            cmd,
  vlsu_buf_if.seq            buf_if,
  // Memory request
  output logic               mem_valid_o,
  input  logic               mem_ready_i,
  output elen_t              mem_addr_o,
  output logic               mem_we_o,
  output strb_t              mem_strb_o,
  output elen_t              mem_wdata_o,
  output logic [IdWidth-1:0] mem_id_o,
  output logic               mem_last_o,
  // Load result
  input  logic               mem_result_valid_i,
  input  logic [IdWidth-1:0] mem_result_id_i,
  input  elen_t              mem_rdata_i
);

  vlen_t      cnt_q;
  vlen_t      remaining;
  vlen_t      step;
  logic       pending;
  logic       last;
  logic       valid;
  logic       handshake;
  elen_t      elem_idx;
  elen_t      addr;
  logic [1:0] offset;

  // Byte offset of every outstanding load, by ROB id
  logic [1:0] off_q [NrOutstandingLoads];

  assign remaining = cmd.total_bytes - cnt_q;
  assign pending   = cmd.active & (remaining != '0);

  always_comb begin
    if (cmd.elem_wise) begin
      step = elem_size(cmd.vsew);
    end else if (remaining < vlen_t'(ELENB)) begin
      step = remaining;
    end else begin
      step = vlen_t'(ELENB);
    end
  end

  assign last = pending & (step == remaining);

  ////////////////////////////////////////
  // Address generation

  assign elem_idx = elen_t'(cnt_q >> cmd.vsew);
  assign addr     = cmd.elem_wise ? cmd.base + elem_idx * cmd.stride
                                  : cmd.base + elen_t'(cnt_q);
  assign offset   = addr[1:0];

  // Loads need a free slot, stores need their data at the head
  assign valid     = pending & (cmd.is_load ? ~buf_if.full : buf_if.head_valid);
  assign handshake = valid & mem_ready_i;

  assign mem_valid_o = valid;
  assign mem_addr_o  = {addr[ELEN-1:2], 2'b00};
  assign mem_we_o    = ~cmd.is_load;
  assign mem_strb_o  = access_strb(cmd.elem_wise, cmd.vsew, offset, step);
  assign mem_id_o    = buf_if.alloc_id;
  assign mem_last_o  = last;
  // Move the element from its register byte position to the memory offset
  assign mem_wdata_o = rotl_bytes(buf_if.head_data, offset - cnt_q[1:0]);

  ////////////////////////////////////////
  // Reorder buffer side

  assign buf_if.alloc     = handshake & cmd.is_load;
  assign buf_if.pop       = handshake & ~cmd.is_load;
  assign buf_if.push      = mem_result_valid_i;
  assign buf_if.push_id   = mem_result_id_i;
  // Results are stored with the element at byte 0
  assign buf_if.push_data = mem_rdata_i >> (8 * off_q[mem_result_id_i]);

  always_ff @(posedge clk_i) begin
    if (buf_if.alloc) begin
      off_q[buf_if.alloc_id] <= offset;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || cmd.start) begin
      cnt_q <= '0;
    end else if (handshake) begin
      cnt_q <= cnt_q + step;
    end
  end

  assign cmd.mem_done = ~cmd.active | (remaining == '0) | (last & handshake);

endmodule

//--- src/vlsu_rob.sv
// Reorder buffer between the memory side and the register file side
module vlsu_rob import vlsu_pkg::*; #(
  parameter  int unsigned NrOutstandingLoads = 4,
  localparam int unsigned IdWidth            = id_width(NrOutstandingLoads)
) (
  input logic     clk_i,
  input logic     reset_i,
  vlsu_cmd_if.mem cmd,
  vlsu_buf_if.rob mem_buf,
  vlsu_buf_if.rob vrf_buf
);

  typedef logic [IdWidth-1:0] id_t;

  elen_t                         data_q [NrOutstandingLoads];
  logic [NrOutstandingLoads-1:0] used_q;   // Allocated, not yet popped
  logic [NrOutstandingLoads-1:0] valid_q;  // Written
  id_t                           wr_ptr_q;
  id_t                           rd_ptr_q;

  logic  alloc;
  logic  push;
  logic  pop;
  id_t   push_id;
  elen_t push_data;

  function automatic id_t next_ptr(id_t ptr);
    return (ptr == id_t'(NrOutstandingLoads - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Loads fill from memory and drain to the VRF, stores the other way round
  always_comb begin
    if (cmd.is_load) begin
      alloc     = mem_buf.alloc;
      push      = mem_buf.push;
      push_id   = mem_buf.push_id;
      push_data = mem_buf.push_data;
      pop       = vrf_buf.pop;
    end else begin
      alloc     = vrf_buf.alloc;
      push      = vrf_buf.push;
      push_id   = vrf_buf.push_id;
      push_data = vrf_buf.push_data;
      pop       = mem_buf.pop;
    end
  end

  assign mem_buf.alloc_id   = wr_ptr_q;
  assign vrf_buf.alloc_id   = wr_ptr_q;
  assign mem_buf.full       = used_q[wr_ptr_q];
  assign vrf_buf.full       = used_q[wr_ptr_q];
  assign mem_buf.head_valid = valid_q[rd_ptr_q];
  assign vrf_buf.head_valid = valid_q[rd_ptr_q];
  assign mem_buf.head_data  = data_q[rd_ptr_q];
  assign vrf_buf.head_data  = data_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i || cmd.start) begin
      used_q   <= '0;
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (alloc) begin
        used_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q         <= next_ptr(wr_ptr_q);
      end
      if (push) begin
        valid_q[push_id] <= 1'b1;
      end
      if (pop) begin
        used_q[rd_ptr_q]  <= 1'b0;
        valid_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q          <= next_ptr(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q[push_id] <= push_data;
    end
  end

endmodule

//--- src/vlsu_vrf_seq.sv
// Register file side sequencer: word addresses, byte enables, load writes and store reads
module vlsu_vrf_seq import vlsu_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  vlsu_cmd_if.vrf    cmd,
  vlsu_buf_if.seq    buf_if,
  // Write port
  output vreg_addr_t vrf_waddr_o,
  output elen_t      vrf_wdata_o,
  output strb_t      vrf_wbe_o,
  output logic       vrf_we_o,
  input  logic       vrf_wvalid_i,
  // Read port
  output vreg_addr_t vrf_raddr_o,
  output logic       vrf_re_o,
  input  elen_t      vrf_rdata_i,
  input  logic       vrf_rvalid_i
);

  vlen_t      cnt_q;
  vlen_t      remaining;
  vlen_t      step;
  logic       pending;
  logic       last;
  logic       wr_done;
  logic       rd_done;
  logic       handshake;
  logic [1:0] byte_pos;
  vreg_addr_t word_addr;

  assign remaining = cmd.total_bytes - cnt_q;
  assign pending   = cmd.active & (remaining != '0);

  always_comb begin
    if (cmd.elem_wise) begin
      step = elem_size(cmd.vsew);
    end else if (remaining < vlen_t'(ELENB)) begin
      step = remaining;
    end else begin
      step = vlen_t'(ELENB);
    end
  end

  assign last      = pending & (step == remaining);
  assign byte_pos  = cnt_q[1:0];
  assign word_addr = vreg_addr_t'(cmd.vd) * vreg_addr_t'(VREG_WORDS)
                   + vreg_addr_t'(cnt_q >> 2);

  ////////////////////////////////////////
  // Loads drain the ROB head

  assign vrf_we_o    = pending & cmd.is_load & buf_if.head_valid;
  assign vrf_waddr_o = word_addr;
  assign vrf_wdata_o = rotl_bytes(buf_if.head_data, byte_pos);
  assign vrf_wbe_o   = access_strb(cmd.elem_wise, cmd.vsew, byte_pos, step);
  assign wr_done     = vrf_we_o & vrf_wvalid_i;
  assign buf_if.pop  = wr_done;

  ////////////////////////////////////////
  // Stores fill the ROB

  // Read only with a free slot to take the word
  assign vrf_re_o         = pending & ~cmd.is_load & ~buf_if.full;
  assign vrf_raddr_o      = word_addr;
  assign rd_done          = vrf_re_o & vrf_rvalid_i;
  assign buf_if.alloc     = rd_done;
  assign buf_if.push      = rd_done;
  assign buf_if.push_id   = buf_if.alloc_id;
  assign buf_if.push_data = vrf_rdata_i;

  assign handshake = wr_done | rd_done;

  always_ff @(posedge clk_i) begin
    if (reset_i || cmd.start) begin
      cnt_q <= '0;
    end else if (handshake) begin
      cnt_q <= cnt_q + step;
    end
  end

  assign cmd.vrf_done = ~cmd.active | (remaining == '0) | (last & handshake);

endmodule

//--- src/vlsu_top.sv
// Vector load/store unit top level joining controller, sequencers and reorder buffer
module vlsu_top import vlsu_pkg::*; #(
  parameter  int unsigned NrOutstandingLoads = 4,
  localparam int unsigned IdWidth            = id_width(NrOutstandingLoads)
) (
  input  logic               clk_i,
  input  logic               reset_i,
  // Instruction in, scoreboard release out
  input  vlsu_req_t          req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output vlsu_rsp_t          rsp_o,
  output logic               rsp_valid_o,
  // Memory port
  output logic               mem_valid_o,
  input  logic               mem_ready_i,
  output elen_t              mem_addr_o,
  output logic               mem_we_o,
  output strb_t              mem_strb_o,
  output elen_t              mem_wdata_o,
  output logic [IdWidth-1:0] mem_id_o,
  output logic               mem_last_o,
  input  logic               mem_result_valid_i,
  input  logic [IdWidth-1:0] mem_result_id_i,
  input  elen_t              mem_rdata_i,
  // Vector register file lane
  output vreg_addr_t         vrf_waddr_o,
  output elen_t              vrf_wdata_o,
  output strb_t              vrf_wbe_o,
  output logic               vrf_we_o,
  input  logic               vrf_wvalid_i,
  output vreg_addr_t         vrf_raddr_o,
  output logic               vrf_re_o,
  input  elen_t              vrf_rdata_i,
  input  logic               vrf_rvalid_i
);

  vlsu_cmd_if cmd_if ();
  vlsu_buf_if #(.NrOutstandingLoads(NrOutstandingLoads)) mem_buf ();
  vlsu_buf_if #(.NrOutstandingLoads(NrOutstandingLoads)) vrf_buf ();

  vlsu_ctrl i_ctrl (
    .cmd (cmd_if),
    .*
  );

  vlsu_mem_seq #(
    .NrOutstandingLoads(NrOutstandingLoads)
  ) i_mem_seq (
    .cmd    (cmd_if),
    .buf_if (mem_buf),
    .*
  );

  vlsu_rob #(
    .NrOutstandingLoads(NrOutstandingLoads)
  ) i_rob (
    .cmd     (cmd_if),
    .mem_buf (mem_buf),
    .vrf_buf (vrf_buf),
    .*
  );

  vlsu_vrf_seq i_vrf_seq (
    .cmd    (cmd_if),
    .buf_if (vrf_buf),
    .*
  );

endmodule

//--- verification/tb_vlsu_models.sv
// Byte memory with random out of order load latency and a vector register file model
module tb_vlsu_models import vlsu_pkg::*; #(
  parameter  int unsigned NrOutstandingLoads = 4,
  parameter  int unsigned Seed               = 0,
  localparam int unsigned IdWidth            = id_width(NrOutstandingLoads)
) (
  input  logic               clk_i,
  input  logic               mem_valid_i,
  output logic               mem_ready_o,
  input  elen_t              mem_addr_i,
  input  logic               mem_we_i,
  input  strb_t              mem_strb_i,
  input  elen_t              mem_wdata_i,
  input  logic [IdWidth-1:0] mem_id_i,
  output logic               mem_result_valid_o,
  output logic [IdWidth-1:0] mem_result_id_o,
  output elen_t              mem_rdata_o,
  input  vreg_addr_t         vrf_waddr_i,
  input  elen_t              vrf_wdata_i,
  input  strb_t              vrf_wbe_i,
  input  logic               vrf_we_i,
  output logic               vrf_wvalid_o,
  input  vreg_addr_t         vrf_raddr_i,
  input  logic               vrf_re_i,
  output elen_t              vrf_rdata_o,
  output logic               vrf_rvalid_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0] mem [256];
  elen_t      vrf [256];

  // Loads in flight, by id
  logic        busy  [NrOutstandingLoads];
  int unsigned delay [NrOutstandingLoads];
  elen_t       data  [NrOutstandingLoads];

  initial begin
    int         seed;
    logic       sent;
    logic [7:0] a;
    seed = Seed;
    void'($urandom(seed));
    mem_ready_o        = 1'b0;
    mem_result_valid_o = 1'b0;
    mem_result_id_o    = '0;
    mem_rdata_o        = '0;
    vrf_wvalid_o       = 1'b0;
    vrf_rdata_o        = '0;
    vrf_rvalid_o       = 1'b0;
    for (int i = 0; i < NrOutstandingLoads; i++) begin
      busy[i] = 1'b0;
    end
    forever begin
      @(posedge clk_i);

      ////////////////////////////////////////
      // Memory

      // Lowest id whose delay ran out goes first, so returns can overtake
      sent = 1'b0;
      mem_result_valid_o <= 1'b0;
      for (int i = 0; i < NrOutstandingLoads; i++) begin
        if (busy[i] && delay[i] != 0) begin
          delay[i]--;
        end
        if (busy[i] && delay[i] == 0 && !sent) begin
          busy[i] = 1'b0;
          sent    = 1'b1;
          mem_result_valid_o <= 1'b1;
          mem_result_id_o    <= IdWidth'(i);
          mem_rdata_o        <= data[i];
        end
      end
      if (mem_valid_i && mem_ready_o) begin
        a = mem_addr_i[7:0];
        if (mem_we_i) begin
          for (int k = 0; k < ELENB; k++) begin
            if (mem_strb_i[k]) begin
              mem[a + 8'(k)] = mem_wdata_i[8*k +: 8];
            end
          end
        end else begin
          busy[mem_id_i]  = 1'b1;
          delay[mem_id_i] = 1 + $urandom % 4;
          data[mem_id_i]  = {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]};
        end
      end
      mem_ready_o <= ($urandom % 4) != 0;

      ////////////////////////////////////////
      // Register file

      if (vrf_we_i && vrf_wvalid_o) begin
        for (int k = 0; k < ELENB; k++) begin
          if (vrf_wbe_i[k]) begin
            vrf[vrf_waddr_i][8*k +: 8] = vrf_wdata_i[8*k +: 8];
          end
        end
        vrf_wvalid_o <= 1'b0;
      end else begin
        vrf_wvalid_o <= vrf_we_i && ($urandom % 2 == 0);
      end
      if (vrf_re_i && vrf_rvalid_o) begin
        vrf_rvalid_o <= 1'b0;
      end else begin
        // Address is held until the ack, so the data matches it
        vrf_rvalid_o <= vrf_re_i && ($urandom % 2 == 0);
        vrf_rdata_o  <= vrf[vrf_raddr_i];
      end
    end
  end

endmodule

//--- verification/tb_vlsu_top.sv
// Testbench for the vector load/store unit with directed load and store tests
module tb_vlsu_top import vlsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NR_OUTSTANDING = 4;
  localparam int unsigned ID_W           = id_width(NR_OUTSTANDING);
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic            clk_i;
  logic            reset_i;
  vlsu_req_t       req_i;
  logic            req_valid_i;
  logic            req_ready_o;
  vlsu_rsp_t       rsp_o;
  logic            rsp_valid_o;
  logic            mem_valid_o;
  logic            mem_ready_i;
  elen_t           mem_addr_o;
  logic            mem_we_o;
  strb_t           mem_strb_o;
  elen_t           mem_wdata_o;
  logic [ID_W-1:0] mem_id_o;
  logic            mem_last_o;
  logic            mem_result_valid_i;
  logic [ID_W-1:0] mem_result_id_i;
  elen_t           mem_rdata_i;
  vreg_addr_t      vrf_waddr_o;
  elen_t           vrf_wdata_o;
  strb_t           vrf_wbe_o;
  logic            vrf_we_o;
  logic            vrf_wvalid_i;
  vreg_addr_t      vrf_raddr_o;
  logic            vrf_re_o;
  elen_t           vrf_rdata_i;
  logic            vrf_rvalid_i;

  // Expected contents of both models
  logic [7:0]  exp_mem [256];
  elen_t       exp_vrf [256];
  int unsigned checks;
  int unsigned errors;
  int unsigned tests;

  vlsu_top #(.NrOutstandingLoads(NR_OUTSTANDING)) uut (.*);

  tb_vlsu_models #(
    .NrOutstandingLoads(NR_OUTSTANDING),
    .Seed              (32'h27af_4d4f)
  ) models (
    .clk_i              (clk_i),
    .mem_valid_i        (mem_valid_o),
    .mem_ready_o        (mem_ready_i),
    .mem_addr_i         (mem_addr_o),
    .mem_we_i           (mem_we_o),
    .mem_strb_i         (mem_strb_o),
    .mem_wdata_i        (mem_wdata_o),
    .mem_id_i           (mem_id_o),
    .mem_result_valid_o (mem_result_valid_i),
    .mem_result_id_o    (mem_result_id_i),
    .mem_rdata_o        (mem_rdata_i),
    .vrf_waddr_i        (vrf_waddr_o),
    .vrf_wdata_i        (vrf_wdata_o),
    .vrf_wbe_i          (vrf_wbe_o),
    .vrf_we_i           (vrf_we_o),
    .vrf_wvalid_o       (vrf_wvalid_i),
    .vrf_raddr_i        (vrf_raddr_o),
    .vrf_re_i           (vrf_re_o),
    .vrf_rdata_o        (vrf_rdata_i),
    .vrf_rvalid_o       (vrf_rvalid_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Compare and report

  task automatic check_word(input string name, input elen_t got, input elen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_rsp(input string name, input vlsu_rsp_t got, input vlsu_rsp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    tests++;
    $display("test %s: %s, %0d errors", name, (errors == errs_before) ? "ok" : "FAILED",
             errors - errs_before);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("%s", what);
  endtask

  ////////////////////////////////////////
  // Model contents

  // Both patterns depend on every address bit
  function automatic logic [7:0] mem_fill(input logic [7:0] a);
    return a * 8'd37 + 8'd11;
  endfunction

  function automatic elen_t reg_fill(input int w);
    return {8'(w), 8'(w * 5 + 3), 8'(~w), 8'(w ^ 8'h96)};
  endfunction

  task automatic preload_models();
    for (int i = 0; i < 256; i++) begin
      models.mem[i] = mem_fill(8'(i));
      exp_mem[i]    = mem_fill(8'(i));
      models.vrf[i] = reg_fill(i);
      exp_vrf[i]    = reg_fill(i);
    end
  endtask

  // Element i sits at memory base + i * stride and at register byte esize * i
  task automatic expect_access(input logic is_load, input vsew_e vsew, input vlen_t vl,
                               input elen_t base, input elen_t stride, input vreg_num_t vd);
    int unsigned esize;
    int unsigned p;
    int unsigned w;
    logic [7:0]  a;
    esize = 1 << vsew;
    for (int i = 0; i < int'(vl); i++) begin
      for (int b = 0; b < int'(esize); b++) begin
        a = 8'(base + i * stride + b);
        p = i * esize + b;
        w = vd * VREG_WORDS + p / 4;
        if (is_load) begin
          exp_vrf[w][8*(p%4) +: 8] = mem_fill(a);
        end else begin
          exp_mem[a] = exp_vrf[w][8*(p%4) +: 8];
        end
      end
    end
  endtask

  task automatic compare_models();
    elen_t got;
    elen_t exp;
    for (int w = 0; w < 256; w++) begin
      check_word($sformatf("vrf[%0d]", w), models.vrf[w], exp_vrf[w]);
    end
    for (int w = 0; w < 64; w++) begin
      for (int k = 0; k < ELENB; k++) begin
        got[8*k +: 8] = models.mem[4*w + k];
        exp[8*k +: 8] = exp_mem[4*w + k];
      end
      check_word($sformatf("mem[%0d]", 4 * w), got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Handshakes

  task automatic send_req(input vlsu_req_t req);
    int unsigned t;
    logic        taken;
    req_i       <= req;
    req_valid_i <= 1'b1;
    t     = 0;
    taken = 1'b0;
    while (!taken && t < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      taken = req_ready_o;
      t++;
    end
    req_valid_i <= 1'b0;
    if (!taken) begin
      report_timeout("request was never accepted");
    end
  endtask

  // Counts memory requests on the way and checks the last flag of each
  task automatic wait_rsp(input int unsigned exp_reqs);
    int unsigned t;
    int unsigned reqs;
    logic        seen;
    t    = 0;
    reqs = 0;
    seen = 1'b0;
    while (!seen && t < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      if (mem_valid_o && mem_ready_i) begin
        reqs++;
        check_bit("mem_last_o", mem_last_o, reqs == exp_reqs);
      end
      seen = rsp_valid_o;
      t++;
    end
    if (!seen) begin
      report_timeout("no response before the timeout");
    end
    check_word("memory requests", elen_t'(reqs), elen_t'(exp_reqs));
  endtask

  task automatic run_access(input string name, input vlsu_op_e op, input vsew_e vsew,
                            input vlen_t vl, input elen_t base, input elen_t stride,
                            input vreg_num_t vd, input trans_id_t id);
    int unsigned errs;
    int unsigned reqs;
    logic        is_load;
    elen_t       step;
    vlsu_req_t   req;
    vlsu_rsp_t   exp_rsp;
    errs    = errors;
    is_load = (op == VLE) || (op == VLSE);
    // Unit stride steps by the element size
    step    = (op == VLE || op == VSE) ? (elen_t'(1) << vsew) : stride;
    req     = '{op: op, vsew: vsew, vl: vl, base: base, stride: stride, vd: vd, id: id};
    exp_rsp = '{id: id, vd: vd};
    // One request per element when strided or unaligned
    if (op == VLSE || op == VSSE || base[1:0] != 2'b00) begin
      reqs = int'(vl);
    end else begin
      reqs = (int'(vl) * (1 << vsew) + 3) / 4;
    end
    preload_models();
    expect_access(is_load, vsew, vl, base, step, vd);
    send_req(req);
    wait_rsp(reqs);
    check_rsp("rsp_o", rsp_o, exp_rsp);
    // Last write lands on this edge
    @(posedge clk_i);
    compare_models();
    report_test(name, errs);
  endtask

  ////////////////////////////////////////
  // Tests

  task automatic test_idle_and_empty();
    int unsigned errs;
    vlsu_req_t   req;
    errs = errors;
    @(posedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    check_bit("mem_valid_o", mem_valid_o, 1'b0);
    check_bit("vrf_we_o", vrf_we_o, 1'b0);
    check_bit("vrf_re_o", vrf_re_o, 1'b0);
    req = '{op: VLE, vsew: EW_32, vl: '0, base: 32'h10, stride: '0, vd: 5'd1, id: 3'd7};
    send_req(req);
    // Nothing may follow an empty instruction
    repeat (10) begin
      @(posedge clk_i);
      check_bit("mem_valid_o", mem_valid_o, 1'b0);
      check_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    end
    report_test("idle and vl zero", errs);
  endtask

  task automatic test_load_words();
    run_access("unit load 32b", VLE, EW_32, 16'd5, 32'h20, '0, 5'd2, 3'd1);
  endtask

  task automatic test_store_bytes();
    run_access("unit store 8b", VSE, EW_8, 16'd10, 32'h60, '0, 5'd4, 3'd2);
  endtask

  task automatic test_load_strided();
    run_access("strided load 16b", VLSE, EW_16, 16'd6, 32'h42, 32'd6, 5'd7, 3'd3);
  endtask

  task automatic test_store_strided();
    run_access("strided store 8b", VSSE, EW_8, 16'd7, 32'h81, 32'd3, 5'd9, 3'd4);
  endtask

  task automatic test_load_unaligned();
    run_access("unaligned load 8b", VLE, EW_8, 16'd7, 32'ha1, '0, 5'd12, 3'd5);
  endtask

  initial begin
    checks      = 0;
    errors      = 0;
    tests       = 0;
    req_i       = '0;
    req_valid_i = 1'b0;
    reset_i     = 1'b1;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    test_idle_and_empty();
    test_load_words();
    test_store_bytes();
    test_load_strided();
    test_store_strided();
    test_load_unaligned();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- files.f
src/vlsu_pkg.sv
src/vlsu_cmd_if.sv
src/vlsu_buf_if.sv
src/vlsu_ctrl.sv
src/vlsu_mem_seq.sv
src/vlsu_rob.sv
src/vlsu_vrf_seq.sv
src/vlsu_top.sv
verification/tb_vlsu_models.sv
verification/tb_vlsu_top.sv
